// ==== verilog/mlc_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Widths, flit header layout and memory message fields shared by the
// link client blocks. Modules take it with a wildcard import.
// ~~~~~~~~~~~~~~~~~~~~
package mlc_pkg;

  localparam int flit_width_c    = 32;
  localparam int cord_width_c    = 8;
  localparam int cid_width_c     = 4;
  localparam int len_width_c     = 4;
  localparam int mem_msg_width_c = 2 * flit_width_c;  // two payload flits.
  localparam int pkt_len_c       = 2;                 // payload flits per packet.

  // memory message fields, opcode on top, data word at the bottom
  localparam int msg_op_lsb_c     = 62;
  localparam int msg_addr_lsb_c   = 32;
  localparam int msg_addr_width_c = 30;
  localparam int msg_data_width_c = 32;

  typedef struct packed {
    logic [cord_width_c-1:0] dst_cord;
    logic [cid_width_c-1:0]  dst_cid;
    logic [len_width_c-1:0]  len;       // payload flits that follow.
    logic [cord_width_c-1:0] src_cord;
    logic [cid_width_c-1:0]  src_cid;
    logic [3:0]              spare;
  } flit_hdr_t;

  // first flit of a packet is a header, the rest are raw words
  typedef union packed {
    flit_hdr_t               hdr;
    logic [flit_width_c-1:0] raw;
  } flit_u;

  typedef enum logic [1:0] {
    mem_rd_e      = 2'b00,
    mem_wr_e      = 2'b01,
    mem_rd_resp_e = 2'b10,
    mem_wr_resp_e = 2'b11
  } mem_opcode_e;

endpackage

// ==== verilog/flit_rx_assembler.sv ====
`timescale 1ns/100ps
// ~~~~~~~~~~~~~~~~~~~~
// Receive side of the command link. Buffers flits under credit flow
// control and assembles header plus two payload flits into one memory
// command with its source address. Valid is gated by the return store.
// ~~~~~~~~~~~~~~~~~~~~
module flit_rx_assembler #(
  parameter int rx_depth_p = 4
) (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic [mlc_pkg::flit_width_c-1:0]    flit_i,
  input  logic                                flit_v_i,
  output logic                                credit_o,
  output logic [mlc_pkg::mem_msg_width_c-1:0] pkt_msg_o,
  output logic [mlc_pkg::cord_width_c-1:0]    pkt_src_cord_o,
  output logic [mlc_pkg::cid_width_c-1:0]     pkt_src_cid_o,
  output logic                                pkt_v_o,
  input  logic                                fifo_ready_i,
  input  logic                                pkt_yumi_i
);
  import mlc_pkg::*;

  localparam int ptr_width_lp = (rx_depth_p > 1) ? $clog2(rx_depth_p) : 1;
  localparam int cnt_width_lp = $clog2(rx_depth_p + 1);

  localparam logic [1:0] st_hdr_lp  = 2'd0;
  localparam logic [1:0] st_pay0_lp = 2'd1;
  localparam logic [1:0] st_pay1_lp = 2'd2;
  localparam logic [1:0] st_full_lp = 2'd3;

  logic [flit_width_c-1:0] buf_mem [rx_depth_p];
  logic [ptr_width_lp-1:0] wr_ptr_r;
  logic [ptr_width_lp-1:0] rd_ptr_r;
  logic [cnt_width_lp-1:0] count_r;
  logic [1:0]              state_r;
  logic                    pkt_v_r;
  logic                    move;
  flit_u                   head;

  function automatic logic [ptr_width_lp-1:0] next_ptr(input logic [ptr_width_lp-1:0] ptr);
    return (ptr == ptr_width_lp'(rx_depth_p - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign move       = (count_r != '0) && (state_r != st_full_lp); // stalls while holding.
  assign head.raw   = buf_mem[rd_ptr_r];
  assign pkt_v_o    = pkt_v_r && fifo_ready_i;

  always_ff @(posedge clk_i) begin
    if (flit_v_i) buf_mem[wr_ptr_r] <= flit_i;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
      credit_o <= 1'b0;
    end else begin
      if (flit_v_i) wr_ptr_r <= next_ptr(wr_ptr_r);
      if (move) rd_ptr_r <= next_ptr(rd_ptr_r);
      count_r  <= count_r + cnt_width_lp'(flit_v_i) - cnt_width_lp'(move);
      credit_o <= move;  // slot freed, credit goes back.
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r <= st_hdr_lp;
      pkt_v_r <= 1'b0;
    end else begin
      case (state_r)
        st_hdr_lp:  if (move) state_r <= st_pay0_lp;
        st_pay0_lp: if (move) state_r <= st_pay1_lp;
        st_pay1_lp: if (move) state_r <= st_full_lp;
        default:    if (pkt_yumi_i) state_r <= st_hdr_lp;
      endcase
      pkt_v_r <= (state_r == st_full_lp) && !pkt_yumi_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (move) begin
      case (state_r)
        st_hdr_lp: begin
          pkt_src_cord_o <= head.hdr.src_cord;
          pkt_src_cid_o  <= head.hdr.src_cid;
        end
        st_pay0_lp: pkt_msg_o[mem_msg_width_c-1 -: flit_width_c] <= head.raw;
        default:    pkt_msg_o[flit_width_c-1:0] <= head.raw;
      endcase
    end
  end

  // sender must respect the credits it was given
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    flit_v_i |-> count_r < cnt_width_lp'(rx_depth_p));
  a_yumi_with_v: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pkt_yumi_i |-> pkt_v_o);
  a_cmd_opcode: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pkt_v_o |-> mem_opcode_e'(pkt_msg_o[msg_op_lsb_c +: $bits(mem_opcode_e)])
                inside {mem_rd_e, mem_wr_e});

endmodule

// ==== verilog/return_addr_fifo.sv ====
`timescale 1ns/100ps
// ~~~~~~~~~~~~~~~~~~~~
// In-order store of the source coordinate and child id of every
// outstanding memory command. Pushed on command yumi, popped when a
// response is taken; an empty store passes a same-cycle push through.
// ~~~~~~~~~~~~~~~~~~~~
module return_addr_fifo #(
  parameter int num_outstanding_req_p = 4
) (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic [mlc_pkg::cord_width_c-1:0] push_cord_i,
  input  logic [mlc_pkg::cid_width_c-1:0]  push_cid_i,
  input  logic                             push_i,
  output logic                             ready_o,
  input  logic                             pop_i,
  output logic [mlc_pkg::cord_width_c-1:0] ret_cord_o,
  output logic [mlc_pkg::cid_width_c-1:0]  ret_cid_o,
  output logic                             ret_v_o
);
  import mlc_pkg::*;

  localparam int entry_width_lp = cord_width_c + cid_width_c;
  localparam int ptr_width_lp   = (num_outstanding_req_p > 1) ? $clog2(num_outstanding_req_p) : 1;
  localparam int cnt_width_lp   = $clog2(num_outstanding_req_p + 1);
  localparam logic [ptr_width_lp-1:0] last_ptr_lp = ptr_width_lp'(num_outstanding_req_p - 1);

  logic [entry_width_lp-1:0] mem_r [num_outstanding_req_p];
  logic [ptr_width_lp-1:0]   wr_ptr_r;
  logic [ptr_width_lp-1:0]   rd_ptr_r;
  logic [cnt_width_lp-1:0]   count_r;
  logic                      empty;
  logic                      wr_en;
  logic                      rd_en;

  assign empty   = (count_r == '0);
  assign wr_en   = push_i && !(empty && pop_i); // bypassed entries are never stored.
  assign rd_en   = pop_i && !empty;
  assign ready_o = (count_r != cnt_width_lp'(num_outstanding_req_p));
  assign ret_v_o = !empty || push_i;
  assign {ret_cord_o, ret_cid_o} = empty ? {push_cord_i, push_cid_i} : mem_r[rd_ptr_r];

  always_ff @(posedge clk_i) begin
    if (wr_en) mem_r[wr_ptr_r] <= {push_cord_i, push_cid_i};
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (wr_en) wr_ptr_r <= (wr_ptr_r == last_ptr_lp) ? '0 : wr_ptr_r + 1'b1;
      if (rd_en) rd_ptr_r <= (rd_ptr_r == last_ptr_lp) ? '0 : rd_ptr_r + 1'b1;
      count_r <= count_r + cnt_width_lp'(wr_en) - cnt_width_lp'(rd_en);
    end
  end

  a_push_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    push_i |-> ready_o);

endmodule

// ==== verilog/flit_tx_serializer.sv ====
`timescale 1ns/100ps
// ~~~~~~~~~~~~~~~~~~~~
// Transmit side of the response link. Latches one memory response with
// its return address and sends header plus two payload flits, one per
// cycle while the credit counter is nonzero.
// ~~~~~~~~~~~~~~~~~~~~
module flit_tx_serializer #(
  parameter int                             link_credits_p = 4,
  parameter logic [mlc_pkg::cord_width_c-1:0] my_cord_p    = '0,
  parameter logic [mlc_pkg::cid_width_c-1:0]  my_cid_p     = '0
) (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic [mlc_pkg::mem_msg_width_c-1:0] resp_msg_i,
  input  logic                                resp_v_i,
  input  logic [mlc_pkg::cord_width_c-1:0]    ret_cord_i,
  input  logic [mlc_pkg::cid_width_c-1:0]     ret_cid_i,
  output logic                                ready_o,
  output logic [mlc_pkg::flit_width_c-1:0]    flit_o,
  output logic                                flit_v_o,
  input  logic                                credit_i
);
  import mlc_pkg::*;

  localparam int cred_width_lp = $clog2(link_credits_p + 1);

  logic [mem_msg_width_c-1:0] msg_r;
  logic [cord_width_c-1:0]    ret_cord_r;
  logic [cid_width_c-1:0]     ret_cid_r;
  logic                       busy_r;
  logic [1:0]                 sel_r;  // 0 header, then payload words.
  logic [cred_width_lp-1:0]   cred_r;
  logic                       send;
  flit_u                      head;

  assign send     = busy_r && (cred_r != '0);
  assign flit_v_o = send;
  assign ready_o  = !busy_r;

  always_comb begin
    head              = '0;
    head.hdr.dst_cord = ret_cord_r;
    head.hdr.dst_cid  = ret_cid_r;
    head.hdr.len      = len_width_c'(pkt_len_c);
    head.hdr.src_cord = my_cord_p;
    head.hdr.src_cid  = my_cid_p;
  end

  always_comb begin
    case (sel_r)
      2'd0:    flit_o = head.raw;
      2'd1:    flit_o = msg_r[mem_msg_width_c-1:msg_addr_lsb_c];
      default: flit_o = msg_r[msg_data_width_c-1:0];
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (resp_v_i) begin
      msg_r      <= resp_msg_i;
      ret_cord_r <= ret_cord_i;
      ret_cid_r  <= ret_cid_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_r <= 1'b0;
      sel_r  <= '0;
      cred_r <= cred_width_lp'(link_credits_p);
    end else begin
      if (resp_v_i) begin
        busy_r <= 1'b1;
        sel_r  <= '0;
      end else if (send) begin
        if (sel_r == 2'(pkt_len_c)) begin
          busy_r <= 1'b0;  // last payload flit out.
          sel_r  <= '0;
        end else begin
          sel_r <= sel_r + 1'b1;
        end
      end
      cred_r <= cred_r + cred_width_lp'(credit_i) - cred_width_lp'(send);
    end
  end

  // receiver returns no more credits than it was granted
  a_cred_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cred_r <= cred_width_lp'(link_credits_p));

endmodule

// ==== verilog/mem_link_client.sv ====
`timescale 1ns/100ps
// ~~~~~~~~~~~~~~~~~~~~
// Memory-side client of the wormhole network. Turns command packets
// into memory commands and memory responses into packets addressed
// back to the requester. Responses must return in command order.
// ~~~~~~~~~~~~~~~~~~~~
module mem_link_client #(
  parameter int                               num_outstanding_req_p = 4,
  parameter int                               rx_depth_p            = 4,
  parameter int                               link_credits_p        = 4,
  parameter logic [mlc_pkg::cord_width_c-1:0] my_cord_p             = '0,
  parameter logic [mlc_pkg::cid_width_c-1:0]  my_cid_p              = '0
) (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic [mlc_pkg::flit_width_c-1:0]    cmd_flit_i,
  input  logic                                cmd_flit_v_i,
  output logic                                cmd_credit_o,
  output logic [mlc_pkg::flit_width_c-1:0]    resp_flit_o,
  output logic                                resp_flit_v_o,
  input  logic                                resp_credit_i,
  output logic [mlc_pkg::mem_msg_width_c-1:0] mem_cmd_o,
  output logic                                mem_cmd_v_o,
  input  logic                                mem_cmd_yumi_i,
  input  logic [mlc_pkg::mem_msg_width_c-1:0] mem_resp_i,
  input  logic                                mem_resp_v_i,
  output logic                                mem_resp_ready_o
);
  import mlc_pkg::*;

  logic [cord_width_c-1:0] pkt_src_cord;
  logic [cid_width_c-1:0]  pkt_src_cid;
  logic                    pkt_v;
  logic                    fifo_ready;
  logic [cord_width_c-1:0] ret_cord;
  logic [cid_width_c-1:0]  ret_cid;
  logic                    ret_v;
  logic                    ser_ready;
  logic                    resp_take;

  assign mem_cmd_v_o      = pkt_v;
  assign mem_resp_ready_o = ser_ready && ret_v;  // need a return address to reply.
  assign resp_take        = mem_resp_v_i && mem_resp_ready_o;

  flit_rx_assembler #(
    .rx_depth_p(rx_depth_p)
  ) i_flit_rx_assembler (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .flit_i(cmd_flit_i), .flit_v_i(cmd_flit_v_i), .credit_o(cmd_credit_o),
    .pkt_msg_o(mem_cmd_o), .pkt_src_cord_o(pkt_src_cord), .pkt_src_cid_o(pkt_src_cid),
    .pkt_v_o(pkt_v), .fifo_ready_i(fifo_ready), .pkt_yumi_i(mem_cmd_yumi_i)
  );

  return_addr_fifo #(
    .num_outstanding_req_p(num_outstanding_req_p)
  ) i_return_addr_fifo (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .push_cord_i(pkt_src_cord), .push_cid_i(pkt_src_cid), .push_i(mem_cmd_yumi_i),
    .ready_o(fifo_ready), .pop_i(resp_take),
    .ret_cord_o(ret_cord), .ret_cid_o(ret_cid), .ret_v_o(ret_v)
  );

  flit_tx_serializer #(
    .link_credits_p(link_credits_p), .my_cord_p(my_cord_p), .my_cid_p(my_cid_p)
  ) i_flit_tx_serializer (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .resp_msg_i(mem_resp_i), .resp_v_i(resp_take),
    .ret_cord_i(ret_cord), .ret_cid_i(ret_cid), .ready_o(ser_ready),
    .flit_o(resp_flit_o), .flit_v_o(resp_flit_v_o), .credit_i(resp_credit_i)
  );

endmodule

// ==== sim/tb_mem_link_client.sv ====
`timescale 1ns/100ps
// ~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the memory link client. Acts as command link
// sender, response link receiver and in-order memory controller.
// ~~~~~~~~~~~~~~~~~~~~
module tb_mem_link_client;
  import mlc_pkg::*;

  localparam int num_out_lp = 4;
  localparam int rx_depth_lp = 4;
  localparam int link_credits_lp = 4;
  localparam logic [cord_width_c-1:0] my_cord_lp = 8'h35;
  localparam logic [cid_width_c-1:0] my_cid_lp = 4'h9;
  localparam int limit_lp = 200;  // cycles per wait.

  logic clk_i = 1'b0;
  logic arst_n_i = 1'b0;
  logic [flit_width_c-1:0] cmd_flit_i = '0;
  logic cmd_flit_v_i = 1'b0;
  logic cmd_credit_o;
  logic [flit_width_c-1:0] resp_flit_o;
  logic resp_flit_v_o;
  logic resp_credit_i = 1'b0;
  logic [mem_msg_width_c-1:0] mem_cmd_o;
  logic mem_cmd_v_o;
  logic mem_cmd_yumi_i = 1'b0;
  logic [mem_msg_width_c-1:0] mem_resp_i = '0;
  logic mem_resp_v_i = 1'b0;
  logic mem_resp_ready_o;

  int errors = 0;
  int mon_errors = 0;
  int flits_sent = 0;
  int cmd_credits_back = 0;
  int flits_rcvd = 0;
  int credits_given = 0;
  logic withhold = 1'b0;
  logic [flit_width_c-1:0] resp_q [$];
  logic [mem_msg_width_c-1:0] cmds [8];
  logic [mem_msg_width_c-1:0] resps [8];

  mem_link_client #(
    .num_outstanding_req_p(num_out_lp), .rx_depth_p(rx_depth_lp),
    .link_credits_p(link_credits_lp), .my_cord_p(my_cord_lp), .my_cid_p(my_cid_lp)
  ) i_mem_link_client (.*);

  always #4 clk_i = ~clk_i;

  always @(negedge clk_i) begin  // mid-cycle link monitor.
    if (resp_flit_v_o) begin
      resp_q.push_back(resp_flit_o);
      flits_rcvd++;
    end
    if (cmd_credit_o) begin
      cmd_credits_back++;
      if (cmd_credits_back > flits_sent) begin
        $display("[ERROR] %0t: more command credits returned than flits sent", $time);
        mon_errors++;
      end
    end
  end

  always @(posedge clk_i) begin  // receiver gives one credit back per cycle.
    #1;
    resp_credit_i = !withhold && (credits_given < flits_rcvd);
    if (resp_credit_i) credits_given++;
  end

  task automatic report_mismatch(input string what, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
    errors++;
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("tests failed");
    $finish;
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  function automatic logic [cord_width_c-1:0] src_cord(input int i);
    return 8'h20 + 8'(3 * i);
  endfunction

  function automatic logic [cid_width_c-1:0] src_cid(input int i);
    return 4'(i + 1);
  endfunction

  task automatic fill_msgs(input int n);
    for (int i = 0; i < n; i++) begin
      cmds[i] = {($urandom_range(1) != 0) ? mem_wr_e : mem_rd_e,
                 msg_addr_width_c'($urandom), $urandom};
      resps[i] = {mem_rd_resp_e, msg_addr_width_c'($urandom), $urandom};
    end
  endtask

  task automatic send_cmd_packet(input int i);
    flit_u flits [3];
    int t;
    flits[0] = '0;
    flits[0].hdr.dst_cord = my_cord_lp;
    flits[0].hdr.dst_cid = my_cid_lp;
    flits[0].hdr.len = len_width_c'(pkt_len_c);
    flits[0].hdr.src_cord = src_cord(i);
    flits[0].hdr.src_cid = src_cid(i);
    flits[1].raw = cmds[i][63:32];
    flits[2].raw = cmds[i][31:0];
    for (int k = 0; k < 3; k++) begin
      t = 0;
      while (flits_sent - cmd_credits_back >= rx_depth_lp) begin
        next_cycle();
        t++;
        if (t > limit_lp) abort_on_timeout("a command link credit");
      end
      cmd_flit_i = flits[k].raw;
      cmd_flit_v_i = 1'b1;
      flits_sent++;
      next_cycle();
      cmd_flit_v_i = 1'b0;
    end
  endtask

  task automatic take_cmd(input logic [63:0] exp, input int hold, input logic bypass,
                          input logic [63:0] resp);
    int t;
    t = 0;
    while (!mem_cmd_v_o) begin
      next_cycle();
      t++;
      if (t > limit_lp) abort_on_timeout("mem_cmd_v_o");
    end
    if (mem_cmd_o !== exp) report_mismatch("mem_cmd_o", mem_cmd_o, exp);
    repeat (hold) begin
      next_cycle();
      if (!mem_cmd_v_o) report_mismatch("mem_cmd_v_o before yumi", 64'(mem_cmd_v_o), 64'd1);
      if (mem_cmd_o !== exp) report_mismatch("held mem_cmd_o", mem_cmd_o, exp);
    end
    mem_cmd_yumi_i = 1'b1;
    mem_resp_i = resp;
    mem_resp_v_i = bypass;  // response in the yumi cycle.
    @(negedge clk_i);
    if (bypass && !mem_resp_ready_o) begin
      $display("[ERROR] %0t: response was not accepted in the yumi cycle", $time);
      errors++;
    end
    next_cycle();
    mem_cmd_yumi_i = 1'b0;
    mem_resp_v_i = 1'b0;
  endtask

  task automatic give_resp(input logic [63:0] resp);
    int t;
    t = 0;
    mem_resp_i = resp;
    mem_resp_v_i = 1'b1;
    @(negedge clk_i);
    while (!mem_resp_ready_o) begin
      t++;
      if (t > limit_lp) abort_on_timeout("mem_resp_ready_o");
      @(negedge clk_i);
    end
    next_cycle();
    mem_resp_v_i = 1'b0;
  endtask

  task automatic mem_serve(input int i);
    take_cmd(cmds[i], 0, 1'b0, '0);
    give_resp(resps[i]);
  endtask

  task automatic expect_resp_packet(input int i);
    flit_u exp_hdr;
    logic [flit_width_c-1:0] got [3];
    int t;
    t = 0;
    exp_hdr = '0;
    exp_hdr.hdr.dst_cord = src_cord(i);
    exp_hdr.hdr.dst_cid = src_cid(i);
    exp_hdr.hdr.len = len_width_c'(pkt_len_c);
    exp_hdr.hdr.src_cord = my_cord_lp;
    exp_hdr.hdr.src_cid = my_cid_lp;
    while (resp_q.size() < 3) begin
      next_cycle();
      t++;
      if (t > limit_lp) abort_on_timeout("a response packet");
    end
    for (int k = 0; k < 3; k++) got[k] = resp_q.pop_front();
    if (got[0] !== exp_hdr.raw) report_mismatch("resp header", 64'(got[0]), 64'(exp_hdr.raw));
    if (got[1] !== resps[i][63:32]) report_mismatch("resp word 0", 64'(got[1]), resps[i] >> 32);
    if (got[2] !== resps[i][31:0]) report_mismatch("resp word 1", 64'(got[2]), 64'(resps[i][31:0]));
  endtask

  task automatic wait_credits_settled();
    int t;
    t = 0;
    while (cmd_credits_back != flits_sent || credits_given != flits_rcvd) begin
      next_cycle();
      t++;
      if (t > limit_lp) abort_on_timeout("all link credits to return");
    end
  endtask

  task automatic send_and_take(input int n, input int takes);
    fork
      for (int i = 0; i < n; i++) send_cmd_packet(i);
      for (int j = 0; j < takes; j++) take_cmd(cmds[j], 0, 1'b0, '0);
    join
  endtask

  initial begin
    void'($urandom(32'h431d_7240));
    repeat (2) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    next_cycle();
    if (cmd_credit_o || resp_flit_v_o || mem_cmd_v_o || mem_resp_ready_o) begin
      $display("[ERROR] %0t: an output is high after reset", $time);
      errors++;
    end
    // single read
    fill_msgs(1);
    cmds[0][msg_op_lsb_c +: 2] = mem_rd_e;
    send_cmd_packet(0);
    mem_serve(0);
    expect_resp_packet(0);
    wait_credits_settled();
    // three outstanding answered in order
    fill_msgs(3);
    send_and_take(3, 3);
    for (int i = 0; i < 3; i++) begin
      give_resp(resps[i]);
      expect_resp_packet(i);
    end
    wait_credits_settled();
    // response link stalls on withheld credits
    fill_msgs(3);
    send_and_take(3, 3);
    withhold = 1'b1;
    give_resp(resps[0]);
    give_resp(resps[1]);
    repeat (16) begin
      next_cycle();
      if (mem_resp_ready_o) report_mismatch("stalled mem_resp_ready_o", 64'd1, 64'd0);
    end
    if (resp_q.size() != link_credits_lp)
      report_mismatch("flits on held credits", 64'(resp_q.size()), 64'(link_credits_lp));
    withhold = 1'b0;
    expect_resp_packet(0);
    expect_resp_packet(1);
    give_resp(resps[2]);
    expect_resp_packet(2);
    wait_credits_settled();
    // second packet waits in the buffer while yumi is low
    fill_msgs(2);
    fork
      begin
        send_cmd_packet(0);
        send_cmd_packet(1);
      end
      take_cmd(cmds[0], 12, 1'b0, '0);
    join
    if (flits_sent - cmd_credits_back != 3)
      report_mismatch("unreturned cmd credits", 64'(flits_sent - cmd_credits_back), 64'd3);
    give_resp(resps[0]);
    expect_resp_packet(0);
    mem_serve(1);
    expect_resp_packet(1);
    wait_credits_settled();
    // return store full
    fill_msgs(5);
    send_and_take(5, 4);
    repeat (20) begin
      next_cycle();
      if (mem_cmd_v_o) report_mismatch("mem_cmd_v_o with store full", 64'd1, 64'd0);
    end
    give_resp(resps[0]);
    expect_resp_packet(0);
    take_cmd(cmds[4], 0, 1'b0, '0);
    for (int i = 1; i < 5; i++) begin
      give_resp(resps[i]);
      expect_resp_packet(i);
    end
    wait_credits_settled();
    // response in the yumi cycle with an empty store
    fill_msgs(1);
    send_cmd_packet(0);
    take_cmd(cmds[0], 0, 1'b1, resps[0]);
    expect_resp_packet(0);
    wait_credits_settled();
    $display("%0d errors, %0d of them from monitors", errors + mon_errors, mon_errors);
    if (errors + mon_errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// ==== list.f ====
verilog/mlc_pkg.sv
verilog/flit_rx_assembler.sv
verilog/return_addr_fifo.sv
verilog/flit_tx_serializer.sv
verilog/mem_link_client.sv
sim/tb_mem_link_client.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and judges the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_mem_link_client -f list.f -o tb_sim > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "tests failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "all tests passed" sim.log || { echo "simulation ended early"; exit 1; }
echo "simulation ok"
